// ==== source/wiscPkg.sv ====
// Shared ISA types for the 16-bit core; siic and rti have encodings only and decode as no-ops
package wiscPkg;

	localparam int DataWidth = 16;

	typedef enum logic [4:0] {
		Halt = 5'b00000, Nop = 5'b00001, Siic = 5'b00010, Rti = 5'b00011,
		J = 5'b00100, Jr = 5'b00101, Jal = 5'b00110, Jalr = 5'b00111,
		Addi = 5'b01000, Subi = 5'b01001, Xori = 5'b01010, Andi = 5'b01011,
		Beqz = 5'b01100, Bnez = 5'b01101, Bltz = 5'b01110, Bgez = 5'b01111,
		St = 5'b10000, Ld = 5'b10001, Slbi = 5'b10010, Stu = 5'b10011,
		Roli = 5'b10100, Slli = 5'b10101, Rori = 5'b10110, Srli = 5'b10111,
		Lbi = 5'b11000, Btr = 5'b11001, Shift = 5'b11010, Arith = 5'b11011,
		Seq = 5'b11100, Slt = 5'b11101, Sle = 5'b11110, Sco = 5'b11111
	} opcodeE;

	typedef enum logic [3:0] {
		Add, Sub, Xor, AndN, And, Rol, Sll, Ror, Srl, PassB
	} aluOpE;

	typedef enum logic [1:0] {Rd, Rt, R7} destSelE;

	typedef enum logic [1:0] {AluRes, MemData, Link, Flag} wbSelE;

	typedef enum logic [1:0] {CmpEq, CmpLt, CmpLe, CmpCarry} cmpKindE;

	// One level per control line, all zero means no-op
	typedef struct packed {
		logic regWrite;
		destSelE destSel;
		logic aluSrc;
		aluOpE aluOp;
		logic invA;
		logic invB;
		logic immShort;
		logic signExt;
		logic memWrite;
		logic memRead;
		wbSelE wbSel;
		logic branch;
		logic jump;
		logic jumpReg;
		logic halt;
		cmpKindE cmpKind;
		logic btr;
		logic slbi;
		logic lbi;
		logic stu;
	} ctrlBundle;

endpackage

// ==== source/control.sv ====
// Purely combinational decode of instr[15:11]; unknown, siic and rti opcodes act as nop
`timescale 1ns/1ps

module control import wiscPkg::*; (
	input logic [DataWidth-1:0] instr,
	output ctrlBundle ctrl
);

	opcodeE op;
	logic [1:0] func;

	assign op = opcodeE'(instr[15:11]);
	assign func = instr[1:0];

	always_comb begin
		ctrl = '0;
		case (op)
			Halt: ctrl.halt = 1'b1;
			Addi, Subi, Xori, Andi: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = Rt;
				ctrl.aluSrc = 1'b1;
				ctrl.immShort = 1'b1;
				// Only addi and subi sign-extend
				ctrl.signExt = (op == Addi) || (op == Subi);
				case (op)
					Subi: begin
						ctrl.aluOp = Sub;
						ctrl.invA = 1'b1;
					end
					Xori: ctrl.aluOp = Xor;
					Andi: ctrl.aluOp = And;
					default: ctrl.aluOp = Add;
				endcase
			end
			Roli, Slli, Rori, Srli: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = Rt;
				ctrl.aluSrc = 1'b1;
				ctrl.immShort = 1'b1;
				// Rotate or shift kind sits in the low opcode bits
				ctrl.aluOp = aluOpE'(Rol + instr[12:11]);
			end
			St, Ld, Stu: begin
				ctrl.aluSrc = 1'b1;
				ctrl.immShort = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.memWrite = (op != Ld);
				ctrl.memRead = (op == Ld);
				ctrl.regWrite = (op != St);
				ctrl.destSel = Rt;
				ctrl.wbSel = (op == Ld) ? MemData : AluRes;
				ctrl.stu = (op == Stu);
			end
			Lbi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.aluOp = PassB;
				ctrl.lbi = 1'b1;
			end
			Slbi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.slbi = 1'b1;
			end
			Btr, Arith, Shift: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = Rd;
				ctrl.btr = (op == Btr);
				if (op == Shift) begin
					ctrl.aluOp = aluOpE'(Rol + func);
				end else if (op == Arith) begin
					ctrl.aluOp = aluOpE'(func);
					// sub is rt minus rs, andn is rs and not rt
					ctrl.invA = (func == 2'b01);
					ctrl.invB = (func == 2'b11);
				end
			end
			Seq, Slt, Sle, Sco: begin
				ctrl.regWrite = 1'b1;
				ctrl.destSel = Rd;
				ctrl.wbSel = Flag;
				ctrl.cmpKind = cmpKindE'(instr[12:11]);
			end
			Beqz, Bnez, Bltz, Bgez: begin
				ctrl.branch = 1'b1;
				ctrl.signExt = 1'b1;
			end
			J, Jr, Jal, Jalr: begin
				ctrl.jump = 1'b1;
				ctrl.jumpReg = (op == Jr) || (op == Jalr);
				ctrl.signExt = 1'b1;
				if (op == Jal || op == Jalr) begin
					ctrl.regWrite = 1'b1;
					ctrl.destSel = R7;
					ctrl.wbSel = Link;
				end
			end
			default: ctrl = '0;
		endcase
	end

endmodule

// ==== source/regFile.sv ====
// Eight registers, reads are combinational and return the old value during a write
`timescale 1ns/1ps

module regFile import wiscPkg::*; (
	input logic clk,
	input logic rst,
	input logic [2:0] readAddrA,
	input logic [2:0] readAddrB,
	input logic [2:0] writeAddr,
	input logic [DataWidth-1:0] writeData,
	input logic writeEn,
	output logic [DataWidth-1:0] readDataA,
	output logic [DataWidth-1:0] readDataB
);

	logic [DataWidth-1:0] regs [8];

	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

	always_ff @(posedge clk) begin
		if (rst) begin
			regs <= '{default: '0};
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

// ==== source/execute.sv ====
// Combinational datapath; rotates and shifts use only the low four bits of the amount
`timescale 1ns/1ps

module execute import wiscPkg::*; (
	input ctrlBundle ctrl,
	input logic [DataWidth-1:0] rsData,
	input logic [DataWidth-1:0] rtData,
	input logic [DataWidth-1:0] instr,
	input logic [DataWidth-1:0] pcPlus2,
	output logic [DataWidth-1:0] result,
	output logic flag,
	output logic taken,
	output logic [DataWidth-1:0] target
);

	logic [DataWidth-1:0] imm, bIn, opA, opB, aluRes, reversed;
	logic [2*DataWidth-1:0] rotL, rotR;
	logic [DataWidth:0] sumFull;
	logic [3:0] shamt;
	logic cin, cond;

	// J displacement, then 5-bit or 8-bit immediates
	always_comb begin
		if (ctrl.jump && !ctrl.jumpReg) begin
			imm = {{(DataWidth-11){instr[10]}}, instr[10:0]};
		end else if (ctrl.immShort) begin
			imm = {{(DataWidth-5){ctrl.signExt & instr[4]}}, instr[4:0]};
		end else begin
			imm = {{(DataWidth-8){ctrl.signExt & instr[7]}}, instr[7:0]};
		end
	end

	assign bIn = ctrl.aluSrc ? imm : rtData;
	assign opA = ctrl.invA ? ~rsData : rsData;
	assign opB = ctrl.invB ? ~bIn : bIn;
	assign shamt = bIn[3:0];
	assign cin = (ctrl.aluOp == Sub);
	assign sumFull = {1'b0, opA} + {1'b0, opB} + {{DataWidth{1'b0}}, cin};
	assign rotL = {opA, opA} << shamt;
	assign rotR = {opA, opA} >> shamt;
	assign reversed = {<<{rsData}};

	always_comb begin
		case (ctrl.aluOp)
			Add, Sub: aluRes = sumFull[DataWidth-1:0];
			Xor: aluRes = opA ^ opB;
			And, AndN: aluRes = opA & opB;
			Rol: aluRes = rotL[2*DataWidth-1:DataWidth];
			Sll: aluRes = opA << shamt;
			Ror: aluRes = rotR[DataWidth-1:0];
			Srl: aluRes = opA >> shamt;
			PassB: aluRes = opB;
			default: aluRes = '0;
		endcase
	end

	assign result = ctrl.btr ? reversed : ctrl.slbi ? ((rsData << 8) | imm) : aluRes;

	// Sco relies on the adder running rs plus rt
	always_comb begin
		case (ctrl.cmpKind)
			CmpEq: flag = (rsData == rtData);
			CmpLt: flag = ($signed(rsData) < $signed(rtData));
			CmpLe: flag = ($signed(rsData) <= $signed(rtData));
			default: flag = sumFull[DataWidth];
		endcase
	end

	// Branch kind sits in the low opcode bits
	always_comb begin
		case (instr[12:11])
			2'b00: cond = (rsData == '0);
			2'b01: cond = (rsData != '0);
			2'b10: cond = rsData[DataWidth-1];
			default: cond = !rsData[DataWidth-1];
		endcase
	end

	assign taken = ctrl.branch & cond;
	assign target = (ctrl.jumpReg ? rsData : pcPlus2) + imm;

endmodule

// ==== source/dataMem.sv ====
// Word memory with no reset; MemWords must be a power of two so the address wraps
`timescale 1ns/1ps

module dataMem import wiscPkg::*; #(
	parameter int MemWords = 64
) (
	input logic clk,
	input logic writeEn,
	input logic [DataWidth-1:0] addr,
	input logic [DataWidth-1:0] writeData,
	output logic [DataWidth-1:0] readData
);

	localparam int IdxBits = $clog2(MemWords);

	logic [DataWidth-1:0] mem [MemWords];
	logic [IdxBits-1:0] idx;

	// Byte address, bit 0 ignored
	assign idx = addr[IdxBits:1];
	assign readData = mem[idx];

	always_ff @(posedge clk) begin
		if (writeEn) mem[idx] <= writeData;
	end

endmodule

// ==== source/cpuCore.sv ====
// Single-cycle core with instruction fetch left to the caller via pc; halt holds until reset
`timescale 1ns/1ps

module cpuCore import wiscPkg::*; #(
	parameter int MemWords = 64
) (
	input logic clk,
	input logic rst,
	input logic [DataWidth-1:0] instr,
	output logic [DataWidth-1:0] pc,
	output logic halted,
	output logic wbValid,
	output logic [2:0] wbReg,
	output logic [DataWidth-1:0] wbData
);

	ctrlBundle ctrl;
	logic [DataWidth-1:0] rsData, rtData, result, target, memData, pcPlus2, nextPc;
	logic flag, taken, regWe, memWe;

	control uControl (.instr(instr), .ctrl(ctrl));

	regFile uRegFile (
		.clk(clk), .rst(rst),
		.readAddrA(instr[10:8]), .readAddrB(instr[7:5]),
		.writeAddr(wbReg), .writeData(wbData), .writeEn(regWe),
		.readDataA(rsData), .readDataB(rtData)
	);

	execute uExecute (
		.ctrl(ctrl), .rsData(rsData), .rtData(rtData), .instr(instr), .pcPlus2(pcPlus2),
		.result(result), .flag(flag), .taken(taken), .target(target)
	);

	dataMem #(.MemWords(MemWords)) uDataMem (
		.clk(clk), .writeEn(memWe), .addr(result), .writeData(rtData), .readData(memData)
	);

	assign pcPlus2 = pc + 16'd2;
	assign regWe = ctrl.regWrite && !halted && !rst;
	assign memWe = ctrl.memWrite && !halted && !rst;
	assign wbValid = regWe;

	// I2-format writers and stu target rs
	always_comb begin
		if (ctrl.stu || ctrl.lbi || ctrl.slbi) wbReg = instr[10:8];
		else if (ctrl.destSel == R7) wbReg = 3'd7;
		else if (ctrl.destSel == Rt) wbReg = instr[7:5];
		else wbReg = instr[4:2];
	end

	always_comb begin
		case (ctrl.wbSel)
			MemData: wbData = ctrl.memRead ? memData : '0;
			Link: wbData = pcPlus2;
			Flag: wbData = {{(DataWidth-1){1'b0}}, flag};
			default: wbData = result;
		endcase
	end

	// Halt keeps pc on the halt instruction
	assign nextPc = ctrl.halt ? pc : (ctrl.jump || taken) ? target : pcPlus2;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			halted <= 1'b0;
		end else if (!halted) begin
			pc <= nextPc;
			halted <= ctrl.halt;
		end
	end

endmodule

// ==== test/cpuCore_props.sv ====
// Assertions bound into every cpuCore instance; they watch the internal control bundle
`timescale 1ns/1ps

module cpuCore_props import wiscPkg::*; (
	input logic clk,
	input logic rst,
	input ctrlBundle ctrl,
	input logic [DataWidth-1:0] pc,
	input logic halted,
	input logic wbValid
);

	noMemBoth: assert property (@(posedge clk) !(ctrl.memWrite && ctrl.memRead))
		else $error("memWrite and memRead are high together");

	pcEven: assert property (@(posedge clk) disable iff (rst) !pc[0])
		else $error("pc holds an odd address");

	// Halt freezes the fetch address
	pcHeld: assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pc))
		else $error("pc moved while halted");

	noWbInReset: assert property (@(posedge clk) rst |-> !wbValid)
		else $error("wbValid is high during reset");

endmodule

bind cpuCore cpuCore_props uProps (
	.clk(clk), .rst(rst), .ctrl(ctrl), .pc(pc), .halted(halted), .wbValid(wbValid)
);

// ==== test/cpuCoreTb.sv ====
// Reads test/cpuTrace.txt relative to the project root; image is 64 words, unlisted words are halt
`timescale 1ns/1ps

module cpuCoreTb;

	localparam int MaxCycles = 500;

	logic clk = 1'b0;
	logic rst;
	logic [15:0] instr, pc, wbData, haltPc;
	logic halted, wbValid;
	logic [2:0] wbReg;

	logic [15:0] image [64];
	logic [15:0] expPc [64];
	logic expValid [64];
	logic [2:0] expReg [64];
	logic [15:0] expData [64];
	int numRecs, recIdx, valueErrors, otherErrors, cycles;

	cpuCore #(.MemWords(64)) DUT (
		.clk(clk), .rst(rst), .instr(instr), .pc(pc), .halted(halted),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	always #5 clk = ~clk;

	task automatic reportMismatch(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
		valueErrors++;
	endtask

	task automatic loadTrace();
		int fd, code;
		logic [7:0] tag, regTok;
		logic [15:0] a, w;
		logic [8*100-1:0] rest;
		fd = $fopen("test/cpuTrace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file test/cpuTrace.txt");
			otherErrors++;
		end else begin
			while ($fscanf(fd, " %s", tag) == 1) begin
				if (tag == "#") begin
					code = $fgets(rest, fd);
				end else if (tag == "I") begin
					code = $fscanf(fd, "%h %h", a, w);
					image[a[6:1]] = w;
				end else if (tag == "C") begin
					code = $fscanf(fd, "%h %s", a, regTok);
					expPc[numRecs] = a;
					expValid[numRecs] = (regTok != "-");
					if (regTok != "-") begin
						expReg[numRecs] = 3'(regTok - "0");
						code = $fscanf(fd, "%h", expData[numRecs]);
					end
					numRecs++;
				end else if (tag == "H") begin
					code = $fscanf(fd, "%h", haltPc);
				end else begin
					$display("The trace file holds an unknown record tag");
					otherErrors++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic checkCommit();
		if (recIdx >= numRecs) begin
			$display("Instruction at pc %h has no expected commit record", pc);
			otherErrors++;
		end else begin
			if (pc !== expPc[recIdx])
				reportMismatch("pc", pc, expPc[recIdx]);
			if (wbValid !== expValid[recIdx])
				reportMismatch("wbValid", 16'(wbValid), 16'(expValid[recIdx]));
			if (expValid[recIdx] && wbReg !== expReg[recIdx])
				reportMismatch("wbReg", 16'(wbReg), 16'(expReg[recIdx]));
			if (expValid[recIdx] && wbData !== expData[recIdx])
				reportMismatch("wbData", wbData, expData[recIdx]);
			recIdx++;
		end
	endtask

	initial begin
		rst = 1'b1;
		instr = 16'h0800;
		numRecs = 0;
		recIdx = 0;
		valueErrors = 0;
		otherErrors = 0;
		foreach (image[i]) image[i] = 16'h0000;
		loadTrace();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		cycles = 0;
		while (!halted && cycles < MaxCycles) begin
			instr = image[pc[6:1]];
			#4;
			checkCommit();
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("Timed out after %0d cycles without reaching halt", MaxCycles);
			otherErrors++;
		end
		if (recIdx != numRecs) begin
			$display("Only %0d of %0d commit records were reached", recIdx, numRecs);
			otherErrors++;
		end
		// A writing lbi must be ignored once halted
		repeat (3) begin
			instr = 16'hC185;
			#4;
			if (pc !== haltPc)
				reportMismatch("pc", pc, haltPc);
			if (wbValid !== 1'b0)
				reportMismatch("wbValid", 16'(wbValid), 16'h0000);
			@(negedge clk);
		end
		rst = 1'b1;
		@(negedge clk);
		if (pc !== 16'h0000)
			reportMismatch("pc", pc, 16'h0000);
		if (halted !== 1'b0)
			reportMismatch("halted", 16'(halted), 16'h0000);
		rst = 1'b0;
		$display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== build.f ====
source/wiscPkg.sv
source/control.sv
source/regFile.sv
source/execute.sv
source/dataMem.sv
source/cpuCore.sv
test/cpuCore_props.sv
test/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Run from anywhere; paths resolve against the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module cpuCoreTb -f build.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VcpuCoreTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0

// ==== test/cpuTrace.txt ====
# I byte-address word | C pc reg data, or C pc - for no write | H final halt pc
# All values hex, C records are checked in order, one per committed instruction
I 0000 c185 C 0000 1 ff85
I 0002 913c C 0002 1 853c
I 0004 c207 C 0004 2 0007
I 0006 417d C 0006 3 8539
I 0008 4a85 C 0008 4 fffe
I 000a 51bf C 000a 5 8523
I 000c 5cd6 C 000c 6 0016
I 000e d98c C 000e 3 853a
I 0010 da35 C 0010 5 8535
I 0012 d97a C 0012 6 0006
I 0014 dc37 C 0014 5 7ac2
I 0016 a164 C 0016 3 53c8
I 0018 a9a5 C 0018 5 a780
I 001a b1c6 C 001a 6 f214
I 001c b983 C 001c 4 10a7
I 001e d1d6 C 001e 5 c853
I 0020 d14d C 0020 3 9e00
I 0022 d1d3 C 0022 4 0853
I 0024 c914 C 0024 5 3ca1
I 0026 e37c C 0026 7 0001
I 0028 ea3c C 0028 7 0000
I 002a f25c C 002a 7 0001
I 002c f9dc C 002c 7 0001
I 002e 8223 C 002e -
I 0030 8a63 C 0030 3 853c
I 0032 9aa5 C 0032 2 000c
I 0034 6002 C 0034 -
I 0038 6804 C 0038 -
I 003a 7104 C 003a -
I 0040 79f8 C 0040 -
I 0042 3006 C 0042 7 0044
I 004a 3f0a C 004a 7 004c
I 004e 2f08 C 004e -
I 0054 27f0 C 0054 -
I 0046 0000 C 0046 - H 0046
